// ==== design/decode_issue_pkg.sv ====
/* Decode and issue stage shared types */

package decode_issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] instr_t;

    // Upper five opcode bits, the low two are always 2'b11 for RV32I
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011
    } opcode_class_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_ADD = 2'b00,
        ALU_LOGIC_XOR = 2'b01,
        ALU_LOGIC_OR  = 2'b10,
        ALU_LOGIC_AND = 2'b11
    } alu_logic_op_t;

    ////////////////////////////////////////
    // Function-3 encodings
    localparam logic [2:0] ADD_SUB_FN3 = 3'b000;
    localparam logic [2:0] SLL_FN3     = 3'b001;
    localparam logic [2:0] SLT_FN3     = 3'b010;
    localparam logic [2:0] SLTU_FN3    = 3'b011;
    localparam logic [2:0] XOR_FN3     = 3'b100;
    localparam logic [2:0] SRL_SRA_FN3 = 3'b101;
    localparam logic [2:0] OR_FN3      = 3'b110;
    localparam logic [2:0] AND_FN3     = 3'b111;
    localparam logic [2:0] BLTU_FN3    = 3'b110;
    localparam logic [2:0] BGEU_FN3    = 3'b111;

    ////////////////////////////////////////
    // Execution units
    localparam int ALU_UNIT    = 0;
    localparam int LS_UNIT     = 1;
    localparam int BRANCH_UNIT = 2;
    localparam int NUM_UNITS   = 3;

    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        instr_t instruction;
    } decode_packet_t;

    typedef struct packed {
        unit_mask_t unit_needed;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        opcode_class_t op_class;
        alu_logic_op_t alu_logic_op;
        logic alu_subtract;
        logic alu_lshift;
        logic alu_shifter_path;
        logic alu_slt_path;
        logic rs1_use_regfile;
        logic rs2_use_regfile;
        word_t pre_rs1;
        word_t pre_rs2;
        logic is_load;
        logic is_store;
        logic [11:0] ls_offset;
        logic [20:0] pc_offset;
        logic is_call;
        logic is_return;
        logic br_use_signed;
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t decoded;
        word_t pc;
        logic [2:0] fn3;
        logic instr_30;
    } issue_packet_t;

    typedef struct packed {
        logic [32:0] in1;
        logic [32:0] in2;
        word_t shifter_in;
        logic [4:0] shift_amount;
        alu_logic_op_t logic_op;
        logic subtract;
        logic arith;
        logic lshift;
        logic shifter_path;
        logic slt_path;
    } alu_inputs_t;

    typedef struct packed {
        word_t rs1;
        word_t rs2;
        logic [11:0] offset;
        logic load;
        logic store;
        logic [2:0] fn3;
        logic forwarded_store;
    } ls_inputs_t;

    typedef struct packed {
        word_t rs1;
        word_t rs2;
        logic [20:0] pc_offset;
        word_t issue_pc;
        logic [2:0] fn3;
        logic use_signed;
        logic jal;
        logic jalr;
        logic is_call;
        logic is_return;
    } branch_inputs_t;

endpackage

// ==== design/instr_decoder.sv ====
/* RV32I instruction decoder */

`timescale 1ns/10ps

module instr_decoder (
    input decode_issue_pkg::instr_t instruction,
    input decode_issue_pkg::word_t pc,
    output decode_issue_pkg::decoded_instr_t decoded
);

    decode_issue_pkg::opcode_class_t op;
    logic [2:0] fn3;
    decode_issue_pkg::reg_addr_t rs1;
    decode_issue_pkg::reg_addr_t rs2;
    decode_issue_pkg::reg_addr_t rd;
    logic is_arith;
    logic is_upper;
    logic is_jump;
    logic rs1_link;
    logic rd_link;
    decode_issue_pkg::word_t i_imm;
    decode_issue_pkg::word_t u_imm;
    logic [11:0] s_imm;
    logic [20:0] b_imm;
    logic [20:0] j_imm;

    // Field aliases
    assign op = decode_issue_pkg::opcode_class_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign rd = instruction[11:7];

    assign is_arith = op inside {decode_issue_pkg::ARITH_T, decode_issue_pkg::ARITH_IMM_T};
    assign is_upper = op inside {decode_issue_pkg::LUI_T, decode_issue_pkg::AUIPC_T};
    assign is_jump = op inside {decode_issue_pkg::JAL_T, decode_issue_pkg::JALR_T};

    ////////////////////////////////////////
    // Immediates
    assign i_imm = 32'(signed'(instruction[31:20]));
    assign u_imm = {instruction[31:12], 12'b0};
    assign s_imm = {instruction[31:25], instruction[11:7]};
    assign b_imm = 21'(signed'({instruction[31], instruction[7], instruction[30:25],
                                instruction[11:8], 1'b0}));
    assign j_imm = {instruction[31], instruction[19:12], instruction[20], instruction[30:21], 1'b0};

    // x1 and x5 are the link registers
    assign rs1_link = rs1 inside {5'd1, 5'd5};
    assign rd_link = rd inside {5'd1, 5'd5};

    always_comb begin
        decoded = '0;
        decoded.op_class = op;
        decoded.rs1_addr = rs1;
        decoded.rs2_addr = rs2;
        decoded.rd_addr = rd;

        decoded.unit_needed[decode_issue_pkg::ALU_UNIT] = is_arith | is_upper | is_jump;
        decoded.unit_needed[decode_issue_pkg::LS_UNIT] =
            op inside {decode_issue_pkg::LOAD_T, decode_issue_pkg::STORE_T};
        decoded.unit_needed[decode_issue_pkg::BRANCH_UNIT] =
            is_jump | (op == decode_issue_pkg::BRANCH_T);

        decoded.uses_rs1 = !(is_upper || op == decode_issue_pkg::JAL_T);
        decoded.uses_rs2 = op inside {decode_issue_pkg::BRANCH_T, decode_issue_pkg::STORE_T,
                                      decode_issue_pkg::ARITH_T};
        decoded.uses_rd = !(op inside {decode_issue_pkg::BRANCH_T, decode_issue_pkg::STORE_T});

        // Logic unit op, everything else goes through the adder
        case (fn3)
            decode_issue_pkg::XOR_FN3: decoded.alu_logic_op = decode_issue_pkg::ALU_LOGIC_XOR;
            decode_issue_pkg::OR_FN3: decoded.alu_logic_op = decode_issue_pkg::ALU_LOGIC_OR;
            decode_issue_pkg::AND_FN3: decoded.alu_logic_op = decode_issue_pkg::ALU_LOGIC_AND;
            default: decoded.alu_logic_op = decode_issue_pkg::ALU_LOGIC_ADD;
        endcase
        if (!is_arith)
            decoded.alu_logic_op = decode_issue_pkg::ALU_LOGIC_ADD;

        decoded.alu_subtract = is_arith &&
            (fn3 inside {decode_issue_pkg::SLT_FN3, decode_issue_pkg::SLTU_FN3} ||
             (op == decode_issue_pkg::ARITH_T && fn3 == decode_issue_pkg::ADD_SUB_FN3 &&
              instruction[30]));
        decoded.alu_lshift = ~fn3[2];
        decoded.alu_shifter_path = is_arith &&
            fn3 inside {decode_issue_pkg::SLL_FN3, decode_issue_pkg::SRL_SRA_FN3};
        decoded.alu_slt_path = is_arith &&
            fn3 inside {decode_issue_pkg::SLT_FN3, decode_issue_pkg::SLTU_FN3};

        // Constant ALU operands for upper immediates and link values
        decoded.rs1_use_regfile = !(is_upper || is_jump);
        decoded.rs2_use_regfile = !(is_upper || is_jump || op == decode_issue_pkg::ARITH_IMM_T);
        decoded.pre_rs1 = (is_jump || op == decode_issue_pkg::AUIPC_T) ? pc : '0;
        if (is_upper)
            decoded.pre_rs2 = u_imm;
        else if (is_jump)
            decoded.pre_rs2 = 32'd4;
        else
            decoded.pre_rs2 = i_imm;

        decoded.is_load = op == decode_issue_pkg::LOAD_T;
        decoded.is_store = op == decode_issue_pkg::STORE_T;
        decoded.ls_offset = decoded.is_store ? s_imm : instruction[31:20];

        if (op == decode_issue_pkg::JALR_T)
            decoded.pc_offset = 21'(signed'(instruction[31:20]));
        else if (op == decode_issue_pkg::JAL_T)
            decoded.pc_offset = j_imm;
        else
            decoded.pc_offset = b_imm;

        // Return address stack hints
        decoded.is_call = is_jump && rd_link;
        decoded.is_return = (op == decode_issue_pkg::JALR_T) && rs1_link && (!rd_link || rs1 != rd);
        decoded.br_use_signed = !(fn3 inside {decode_issue_pkg::BLTU_FN3, decode_issue_pkg::BGEU_FN3});
    end

    // Every RV32I class kept here must reach some unit
    always_comb begin
        if (op inside {decode_issue_pkg::LUI_T, decode_issue_pkg::AUIPC_T, decode_issue_pkg::JAL_T,
                       decode_issue_pkg::JALR_T, decode_issue_pkg::BRANCH_T, decode_issue_pkg::LOAD_T,
                       decode_issue_pkg::STORE_T, decode_issue_pkg::ARITH_IMM_T,
                       decode_issue_pkg::ARITH_T})
            assert (decoded.unit_needed != '0)
            else $error("known opcode class %h decoded with no unit", op);
    end

endmodule

// ==== design/issue_stage.sv ====
/* Issue register and issue decision */

`timescale 1ns/10ps

module issue_stage (
    input logic clk,
    input logic rst,
    input decode_issue_pkg::decode_packet_t decode,
    input decode_issue_pkg::decoded_instr_t decoded,
    output logic decode_advance,
    input logic rs_busy_1,
    input logic rs_busy_2,
    input decode_issue_pkg::unit_mask_t unit_ready,
    input logic issue_hold,
    input logic flush,
    output decode_issue_pkg::issue_packet_t issue,
    output logic issue_valid,
    output decode_issue_pkg::unit_mask_t issue_to,
    output logic rs2_conflict
);

    logic stage_valid;
    logic stage_ready;
    logic rs1_conflict;
    logic operands_ready;
    logic units_ready;
    logic instruction_issued;
    decode_issue_pkg::unit_mask_t needed;
    decode_issue_pkg::unit_mask_t unit_operands_ready;

    ////////////////////////////////////////
    // Fetch handshake
    assign stage_ready = ~issue_hold & (~stage_valid | instruction_issued);
    assign decode_advance = decode.valid & stage_ready;

    always_ff @(posedge clk) begin
        if (rst | flush)
            stage_valid <= 1'b0;
        else if (stage_ready)
            stage_valid <= decode.valid;
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            issue.decoded <= decoded;
            issue.pc <= decode.pc;
            issue.fn3 <= decode.instruction[14:12];
            issue.instr_30 <= decode.instruction[30];
        end
    end

    ////////////////////////////////////////
    // Operand hazards
    assign rs1_conflict = rs_busy_1 & issue.decoded.uses_rs1;
    assign rs2_conflict = rs_busy_2 & issue.decoded.uses_rs2;
    assign operands_ready = ~rs1_conflict & ~rs2_conflict;

    // Load-store forwards a pending store value, so only rs1 has to be free
    always_comb begin
        unit_operands_ready = {decode_issue_pkg::NUM_UNITS{operands_ready}};
        unit_operands_ready[decode_issue_pkg::LS_UNIT] = ~rs1_conflict;
    end

    ////////////////////////////////////////
    // Issue decision
    assign issue_valid = stage_valid & ~issue_hold & ~flush;
    assign needed = issue.decoded.unit_needed;

    // Jumps need both ALU and branch, so all needed units go together
    assign units_ready = ((needed & unit_ready & unit_operands_ready) == needed);
    assign instruction_issued = issue_valid & units_ready;
    assign issue_to = instruction_issued ? needed : '0;

    empty_stage_no_issue: assert property (@(posedge clk) disable iff (rst)
        !stage_valid |-> (issue_to == '0))
        else $error("issue_to set with an empty issue register");

    blocked_no_advance: assert property (@(posedge clk) disable iff (rst)
        (stage_valid && !instruction_issued) |-> !decode_advance)
        else $error("decode advanced over a blocked instruction");

endmodule

// ==== design/unit_operand_mux.sv ====
/* Unit operand packet formation */

`timescale 1ns/10ps

module unit_operand_mux (
    input decode_issue_pkg::issue_packet_t issue,
    input logic issue_valid,
    input decode_issue_pkg::word_t rs_data_1,
    input decode_issue_pkg::word_t rs_data_2,
    input logic rs2_conflict,
    output decode_issue_pkg::alu_inputs_t alu_inputs,
    output decode_issue_pkg::ls_inputs_t ls_inputs,
    output decode_issue_pkg::branch_inputs_t branch_inputs
);

    decode_issue_pkg::word_t alu_rs1_data;
    decode_issue_pkg::word_t alu_rs2_data;
    logic unsigned_cmp;

    ////////////////////////////////////////
    // ALU
    assign alu_rs1_data = issue.decoded.rs1_use_regfile ? rs_data_1 : issue.decoded.pre_rs1;
    assign alu_rs2_data = issue.decoded.rs2_use_regfile ? rs_data_2 : issue.decoded.pre_rs2;

    // SLTU compares zero extended operands
    assign unsigned_cmp = issue.decoded.alu_slt_path & (issue.fn3 == decode_issue_pkg::SLTU_FN3);

    always_comb begin
        alu_inputs.in1 = {alu_rs1_data[31] & ~unsigned_cmp, alu_rs1_data};
        alu_inputs.in2 = {alu_rs2_data[31] & ~unsigned_cmp, alu_rs2_data};
        alu_inputs.shifter_in = rs_data_1;
        // Register shifts take rs2 data, immediate shifts the shamt field
        alu_inputs.shift_amount = issue.decoded.rs2_use_regfile ? rs_data_2[4:0]
                                                                : issue.decoded.rs2_addr;
        alu_inputs.logic_op = issue.decoded.alu_logic_op;
        alu_inputs.subtract = issue.decoded.alu_subtract;
        alu_inputs.arith = rs_data_1[31] & issue.instr_30;
        alu_inputs.lshift = issue.decoded.alu_lshift;
        alu_inputs.shifter_path = issue.decoded.alu_shifter_path;
        alu_inputs.slt_path = issue.decoded.alu_slt_path;
    end

    ////////////////////////////////////////
    // Load-store
    always_comb begin
        ls_inputs.rs1 = rs_data_1;
        ls_inputs.rs2 = rs_data_2;
        ls_inputs.offset = issue.decoded.ls_offset;
        ls_inputs.load = issue.decoded.is_load;
        ls_inputs.store = issue.decoded.is_store;
        ls_inputs.fn3 = issue.fn3;
        ls_inputs.forwarded_store = rs2_conflict;
    end

    ////////////////////////////////////////
    // Branch
    always_comb begin
        branch_inputs.rs1 = rs_data_1;
        branch_inputs.rs2 = rs_data_2;
        branch_inputs.pc_offset = issue.decoded.pc_offset;
        branch_inputs.issue_pc = issue.pc;
        branch_inputs.fn3 = issue.fn3;
        branch_inputs.use_signed = issue.decoded.br_use_signed;
        branch_inputs.jal = issue.decoded.op_class == decode_issue_pkg::JAL_T;
        branch_inputs.jalr = issue.decoded.op_class == decode_issue_pkg::JALR_T;
        branch_inputs.is_call = issue.decoded.is_call;
        branch_inputs.is_return = issue.decoded.is_return;
    end

    // A held instruction is either a load or a store, never both
    always_comb begin
        if (issue_valid)
            assert (!(ls_inputs.load && ls_inputs.store))
            else $error("load and store both set at issue");
    end

endmodule

// ==== design/decode_issue_top.sv ====
/* Decode and issue stage top level */

`timescale 1ns/10ps

module decode_issue_top (
    input logic clk,
    input logic rst,
    input decode_issue_pkg::decode_packet_t decode,
    output logic decode_advance,
    output decode_issue_pkg::reg_addr_t rs_addr_1,
    output decode_issue_pkg::reg_addr_t rs_addr_2,
    input decode_issue_pkg::word_t rs_data_1,
    input decode_issue_pkg::word_t rs_data_2,
    input logic rs_busy_1,
    input logic rs_busy_2,
    input decode_issue_pkg::unit_mask_t unit_ready,
    input logic issue_hold,
    input logic flush,
    output decode_issue_pkg::unit_mask_t issue_to,
    output decode_issue_pkg::alu_inputs_t alu_inputs,
    output decode_issue_pkg::ls_inputs_t ls_inputs,
    output decode_issue_pkg::branch_inputs_t branch_inputs
);

    decode_issue_pkg::decoded_instr_t decoded;
    decode_issue_pkg::issue_packet_t issue;
    logic issue_valid;
    logic rs2_conflict;

    // Register file reads come from the held instruction
    assign rs_addr_1 = issue.decoded.rs1_addr;
    assign rs_addr_2 = issue.decoded.rs2_addr;

    instr_decoder decoder (
        .instruction(decode.instruction),
        .pc(decode.pc),
        .decoded(decoded)
    );

    issue_stage issue_ctrl (
        .clk, .rst,
        .decode, .decoded, .decode_advance,
        .rs_busy_1, .rs_busy_2, .unit_ready,
        .issue_hold, .flush,
        .issue, .issue_valid, .issue_to, .rs2_conflict
    );

    unit_operand_mux operands (
        .issue, .issue_valid,
        .rs_data_1, .rs_data_2, .rs2_conflict,
        .alu_inputs, .ls_inputs, .branch_inputs
    );

endmodule

// ==== test/tb_vectors.svh ====
/* Decode and issue test table */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction, pc, rs_data_1, rs_data_2, busy {rs2, rs1},
// unit_ready {branch, ls, alu}, stall cycles, flush
// Register data of zero is replaced by a random word
typedef struct packed {
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] rs_data_1;
    logic [31:0] rs_data_2;
    logic [1:0] busy;
    logic [2:0] ready;
    logic [3:0] stall;
    logic flush;
} vector_t;

localparam int NUM_ROWS = 18;
localparam int MAX_STALL = 3;

localparam vector_t VECTORS [NUM_ROWS] = '{
    // addi x3, x2, -5
    '{32'hffb10193, 32'h00001000, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // sub x5, x6, x7
    '{32'h407302b3, 32'h00001004, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // sltu x8, x9, x10 with rs1 pending
    '{32'h00a4b433, 32'h00001008, 32'h80000001, 32'h7fffffff, 2'b01, 3'b111, 4'd2, 1'b0},
    // slti x4, x1, -1
    '{32'hfff0a213, 32'h0000100c, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // lui x7, 0xabcde, only the ALU ready
    '{32'habcde3b7, 32'h00001010, 32'h0, 32'h0, 2'b00, 3'b001, 4'd1, 1'b0},
    // auipc x9, 0x80000
    '{32'h80000497, 32'h80000114, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // lw x11, 16(x2) with load-store busy
    '{32'h01012583, 32'h00001018, 32'h0, 32'h0, 2'b00, 3'b101, 4'd3, 1'b0},
    // sw x12, -8(x13) with store data pending
    '{32'hfec6ac23, 32'h0000101c, 32'h0, 32'h0, 2'b10, 3'b111, 4'd1, 1'b0},
    // sw x14, 4(x15) with base pending
    '{32'h00e7a223, 32'h00001020, 32'h0, 32'h0, 2'b01, 3'b111, 4'd2, 1'b0},
    // beq x1, x2, -16 with rs2 pending
    '{32'hfe2088e3, 32'h00001024, 32'h0, 32'h0, 2'b10, 3'b111, 4'd2, 1'b0},
    // bltu x3, x4, 8
    '{32'h0041e463, 32'h00001028, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // jal x1, 2048 with branch unit busy
    '{32'h001000ef, 32'h0000102c, 32'h0, 32'h0, 2'b00, 3'b011, 4'd2, 1'b0},
    // jalr x0, 0(x1)
    '{32'h00008067, 32'h00001030, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // jalr x5, -4(x6)
    '{32'hffc302e7, 32'h00001034, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // add x20, x21, x22 flushed
    '{32'h016a8a33, 32'h00001038, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b1},
    // xori x6, x7, 0x7ff
    '{32'h7ff3c313, 32'h0000103c, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // srai x2, x3, 5
    '{32'h4051d113, 32'h00001040, 32'h0, 32'h0, 2'b00, 3'b111, 4'd0, 1'b0},
    // lb x9, -1(x10), rs2 busy but unused
    '{32'hfff50483, 32'h00001044, 32'h0, 32'h0, 2'b10, 3'b111, 4'd1, 1'b0}
};

`endif

// ==== test/tb_decode_issue.sv ====
/* Decode and issue stage testbench */

`timescale 1ns/10ps

module tb_decode_issue;

    `include "tb_vectors.svh"

    localparam int CLK_PERIOD = 20;
    localparam int unsigned SEED = 32'h070f5e21;

    // Opcode bits [6:2]
    localparam logic [4:0] OP_LOAD      = 5'b00000;
    localparam logic [4:0] OP_ARITH_IMM = 5'b00100;
    localparam logic [4:0] OP_AUIPC     = 5'b00101;
    localparam logic [4:0] OP_STORE     = 5'b01000;
    localparam logic [4:0] OP_ARITH     = 5'b01100;
    localparam logic [4:0] OP_LUI       = 5'b01101;
    localparam logic [4:0] OP_BRANCH    = 5'b11000;
    localparam logic [4:0] OP_JALR      = 5'b11001;
    localparam logic [4:0] OP_JAL       = 5'b11011;

    logic clk;
    logic rst;
    decode_issue_pkg::decode_packet_t decode;
    logic decode_advance;
    decode_issue_pkg::reg_addr_t rs_addr_1;
    decode_issue_pkg::reg_addr_t rs_addr_2;
    decode_issue_pkg::word_t rs_data_1;
    decode_issue_pkg::word_t rs_data_2;
    logic rs_busy_1;
    logic rs_busy_2;
    decode_issue_pkg::unit_mask_t unit_ready;
    logic issue_hold;
    logic flush;
    decode_issue_pkg::unit_mask_t issue_to;
    decode_issue_pkg::alu_inputs_t alu_inputs;
    decode_issue_pkg::ls_inputs_t ls_inputs;
    decode_issue_pkg::branch_inputs_t branch_inputs;

    int errors;
    int checks;

    decode_issue_top UUT (
        .clk, .rst,
        .decode, .decode_advance,
        .rs_addr_1, .rs_addr_2, .rs_data_1, .rs_data_2,
        .rs_busy_1, .rs_busy_2, .unit_ready,
        .issue_hold, .flush,
        .issue_to, .alu_inputs, .ls_inputs, .branch_inputs
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_ROWS * (MAX_STALL + 4) + 20) * CLK_PERIOD);
        $display("Timeout: the instruction table did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Rules for expected values

    function automatic logic [2:0] unit_mask_rule(input logic [31:0] instr);
        case (instr[6:2])
            OP_ARITH, OP_ARITH_IMM, OP_LUI, OP_AUIPC: return 3'b001;
            OP_LOAD, OP_STORE: return 3'b010;
            OP_BRANCH: return 3'b100;
            OP_JAL, OP_JALR: return 3'b101;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic uses_rs1_rule(input logic [31:0] instr);
        return !(instr[6:2] inside {OP_LUI, OP_AUIPC, OP_JAL});
    endfunction

    function automatic logic uses_rs2_rule(input logic [31:0] instr);
        return instr[6:2] inside {OP_BRANCH, OP_STORE, OP_ARITH};
    endfunction

    function automatic logic blocked_rule(input logic [31:0] instr, input logic [1:0] busy,
                                          input logic [2:0] ready);
        logic [2:0] mask;
        logic rs1_hazard;
        logic rs2_hazard;
        mask = unit_mask_rule(instr);
        rs1_hazard = busy[0] && uses_rs1_rule(instr);
        // Load-store takes a pending rs2 by forwarding
        rs2_hazard = busy[1] && uses_rs2_rule(instr) && !mask[1];
        return ((mask & ~ready) != 3'b000) || rs1_hazard || rs2_hazard;
    endfunction

    function automatic logic sltu_rule(input logic [31:0] instr);
        return (instr[6:2] inside {OP_ARITH, OP_ARITH_IMM}) && instr[14:12] == 3'b011;
    endfunction

    function automatic logic [32:0] alu_in1_rule(input logic [31:0] instr,
                                                 input logic [31:0] pc,
                                                 input logic [31:0] rs1_data);
        logic [31:0] value;
        case (instr[6:2])
            OP_LUI: value = 32'h0;
            OP_AUIPC, OP_JAL, OP_JALR: value = pc;
            default: value = rs1_data;
        endcase
        return {value[31] & ~sltu_rule(instr), value};
    endfunction

    function automatic logic [32:0] alu_in2_rule(input logic [31:0] instr,
                                                 input logic [31:0] rs2_data);
        logic [31:0] value;
        case (instr[6:2])
            OP_LUI, OP_AUIPC: value = {instr[31:12], 12'h000};
            OP_JAL, OP_JALR: value = 32'd4;
            OP_ARITH_IMM: value = {{20{instr[31]}}, instr[31:20]};
            default: value = rs2_data;
        endcase
        return {value[31] & ~sltu_rule(instr), value};
    endfunction

    function automatic logic subtract_rule(input logic [31:0] instr);
        logic [2:0] fn3;
        fn3 = instr[14:12];
        if (!(instr[6:2] inside {OP_ARITH, OP_ARITH_IMM}))
            return 1'b0;
        return fn3 == 3'b010 || fn3 == 3'b011 ||
               (instr[6:2] == OP_ARITH && fn3 == 3'b000 && instr[30]);
    endfunction

    // Only register and immediate arithmetic uses the logic unit
    function automatic logic [1:0] logic_op_rule(input logic [31:0] instr);
        if (!(instr[6:2] inside {OP_ARITH, OP_ARITH_IMM}))
            return decode_issue_pkg::ALU_LOGIC_ADD;
        case (instr[14:12])
            3'b100: return decode_issue_pkg::ALU_LOGIC_XOR;
            3'b110: return decode_issue_pkg::ALU_LOGIC_OR;
            3'b111: return decode_issue_pkg::ALU_LOGIC_AND;
            default: return decode_issue_pkg::ALU_LOGIC_ADD;
        endcase
    endfunction

    function automatic logic [20:0] branch_offset_rule(input logic [31:0] instr);
        case (instr[6:2])
            OP_JAL: return {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            OP_JALR: return {{9{instr[31]}}, instr[31:20]};
            default: return {{8{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        endcase
    endfunction

    function automatic logic is_link(input logic [4:0] addr);
        return addr == 5'd1 || addr == 5'd5;
    endfunction

    function automatic logic is_call_rule(input logic [31:0] instr);
        return (instr[6:2] inside {OP_JAL, OP_JALR}) && is_link(instr[11:7]);
    endfunction

    function automatic logic is_return_rule(input logic [31:0] instr);
        return instr[6:2] == OP_JALR && is_link(instr[19:15]) &&
               !(is_link(instr[11:7]) && instr[11:7] == instr[19:15]);
    endfunction

    ////////////////////////////////////////
    // Checks

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected)
        else begin
            errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_issue(input int idx);
        logic [31:0] instr;
        logic [31:0] pc;
        logic [4:0] op;
        logic [2:0] mask;
        logic [4:0] shamt;
        string row;
        instr = VECTORS[idx].instruction;
        pc = VECTORS[idx].pc;
        op = instr[6:2];
        mask = unit_mask_rule(instr);
        row = $sformatf("row %0d", idx);
        check_value({row, " issue_to"}, issue_to, mask);
        check_value({row, " rs_addr_1"}, rs_addr_1, instr[19:15]);
        check_value({row, " rs_addr_2"}, rs_addr_2, instr[24:20]);
        if (mask[0]) begin
            check_value({row, " alu in1"}, alu_inputs.in1, alu_in1_rule(instr, pc, rs_data_1));
            check_value({row, " alu in2"}, alu_inputs.in2, alu_in2_rule(instr, rs_data_2));
            check_value({row, " alu subtract"}, alu_inputs.subtract, subtract_rule(instr));
            check_value({row, " alu logic op"}, alu_inputs.logic_op, logic_op_rule(instr));
            if (op == OP_ARITH || op == OP_ARITH_IMM) begin
                shamt = (op == OP_ARITH) ? rs_data_2[4:0] : instr[24:20];
                check_value({row, " alu shift amount"}, alu_inputs.shift_amount, shamt);
            end
        end
        if (mask[1]) begin
            check_value({row, " ls rs1"}, ls_inputs.rs1, rs_data_1);
            check_value({row, " ls rs2"}, ls_inputs.rs2, rs_data_2);
            check_value({row, " ls offset"}, ls_inputs.offset,
                        (op == OP_STORE) ? {instr[31:25], instr[11:7]} : instr[31:20]);
            check_value({row, " ls load"}, ls_inputs.load, op == OP_LOAD);
            check_value({row, " ls store"}, ls_inputs.store, op == OP_STORE);
            check_value({row, " ls fn3"}, ls_inputs.fn3, instr[14:12]);
            check_value({row, " forwarded_store"}, ls_inputs.forwarded_store,
                        rs_busy_2 && op == OP_STORE);
        end
        if (mask[2]) begin
            check_value({row, " branch rs1"}, branch_inputs.rs1, rs_data_1);
            check_value({row, " branch rs2"}, branch_inputs.rs2, rs_data_2);
            check_value({row, " branch fn3"}, branch_inputs.fn3, instr[14:12]);
            check_value({row, " pc_offset"}, branch_inputs.pc_offset, branch_offset_rule(instr));
            check_value({row, " issue_pc"}, branch_inputs.issue_pc, pc);
            check_value({row, " jal"}, branch_inputs.jal, op == OP_JAL);
            check_value({row, " jalr"}, branch_inputs.jalr, op == OP_JALR);
            check_value({row, " is_call"}, branch_inputs.is_call, is_call_rule(instr));
            check_value({row, " is_return"}, branch_inputs.is_return, is_return_rule(instr));
            if (op == OP_BRANCH)
                check_value({row, " use_signed"}, branch_inputs.use_signed,
                            !(instr[14:12] inside {3'b110, 3'b111}));
        end
    endtask

    ////////////////////////////////////////
    // Table loop

    initial begin
        int idx;
        int stall;
        logic blocked;
        logic [31:0] data_1;
        logic [31:0] data_2;
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        decode = '0;
        rs_data_1 = '0;
        rs_data_2 = '0;
        rs_busy_1 = 1'b0;
        rs_busy_2 = 1'b0;
        unit_ready = 3'b111;
        issue_hold = 1'b0;
        flush = 1'b0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("issue_to after reset", issue_to, 3'b000);
        check_value("decode_advance after reset", decode_advance, decode.valid);
        @(posedge clk);
        decode <= {1'b1, VECTORS[0].pc, VECTORS[0].instruction};
        @(negedge clk);
        check_value("decode_advance on first fetch", decode_advance, decode.valid);
        check_value("issue_to while empty", issue_to, 3'b000);

        for (idx = 0; idx < NUM_ROWS; idx++) begin
            while (!decode_advance)
                @(negedge clk);
            // Acceptance edge, the next row waits behind this one
            @(posedge clk);
            stall = int'(VECTORS[idx].stall);
            if (idx + 1 < NUM_ROWS)
                decode <= {1'b1, VECTORS[idx + 1].pc, VECTORS[idx + 1].instruction};
            else
                decode <= '0;
            data_1 = (VECTORS[idx].rs_data_1 != 32'h0) ? VECTORS[idx].rs_data_1 : $urandom();
            data_2 = (VECTORS[idx].rs_data_2 != 32'h0) ? VECTORS[idx].rs_data_2 : $urandom();
            rs_data_1 <= data_1;
            rs_data_2 <= data_2;
            rs_busy_1 <= (stall > 0) ? VECTORS[idx].busy[0] : 1'b0;
            rs_busy_2 <= (stall > 0) ? VECTORS[idx].busy[1] : 1'b0;
            unit_ready <= (stall > 0) ? VECTORS[idx].ready : 3'b111;
            flush <= VECTORS[idx].flush;
            blocked = (stall > 0) &&
                      blocked_rule(VECTORS[idx].instruction, VECTORS[idx].busy,
                                   VECTORS[idx].ready);

            if (VECTORS[idx].flush) begin
                @(negedge clk);
                check_value($sformatf("row %0d issue_to in flush", idx), issue_to, 3'b000);
                check_value($sformatf("row %0d advance in flush", idx), decode_advance, 1'b0);
                @(posedge clk);
                flush <= 1'b0;
                @(negedge clk);
                check_value($sformatf("row %0d issue_to after flush", idx), issue_to, 3'b000);
            end else begin
                if (blocked) begin
                    repeat (stall) begin
                        @(negedge clk);
                        check_value($sformatf("row %0d issue_to stalled", idx), issue_to, 3'b000);
                        check_value($sformatf("row %0d advance stalled", idx),
                                    decode_advance, 1'b0);
                        @(posedge clk);
                    end
                    rs_busy_1 <= 1'b0;
                    rs_busy_2 <= 1'b0;
                    unit_ready <= 3'b111;
                end
                @(negedge clk);
                check_issue(idx);
            end
        end

        @(posedge clk);
        @(negedge clk);
        check_value("issue_to after last row", issue_to, 3'b000);

        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+test
design/decode_issue_pkg.sv
design/instr_decoder.sv
design/issue_stage.sv
design/unit_operand_mux.sv
design/decode_issue_top.sv
test/tb_decode_issue.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP := tb_decode_issue
FILELIST := project.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) test/tb_vectors.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
